// ==== all.f ====
hw/voter_pkg.sv
hw/axil_write_port.sv
hw/set_register_bank.sv
hw/majority_voter.sv
hw/axil_read_port.sv
hw/root_voter_top.sv
tests/root_voter_tb.sv

// ==== hw/axil_read_port.sv ====
/*
 * AXI4-Lite read channel and read-only register mux
 * single outstanding read, RDATA is captured once at accept
 * unmapped indices read as zero, the response is always OKAY
 */
`timescale 1ns/1ps
`default_nettype none

module axil_read_port
	import voter_pkg::*;
(
	input  wire                         S_AXI_ACLK_i,
	input  wire                         S_AXI_ARESETN_i,
	input  wire [addr_width-1:0]        S_AXI_ARADDR_i,
	input  wire                         S_AXI_ARVALID_i,
	output logic                        S_AXI_ARREADY_o,
	output logic [data_width-1:0]       S_AXI_RDATA_o,
	output logic [1:0]                  S_AXI_RRESP_o,
	output logic                        S_AXI_RVALID_o,
	input  wire                         S_AXI_RREADY_i,
	input  wire [data_width-1:0]        majority_i,
	input  wire [set_num-1:0]           disagree_i,
	input  wire                         result_valid_i,
	input  wire [vote_count_width-1:0]  vote_count_i,
	input  wire [set_num-1:0]           set_valid_i
);

	// zero padding widths of the state and status words
	localparam int unsigned state_pad = data_width - $bits(state_signature) - vote_count_width;
	localparam int unsigned status_pad = data_width - (2 * set_num + 1);

	logic                  arready_q;
	logic                  rvalid_q;
	logic [idx_width-1:0]  idx_q;
	logic [data_width-1:0] rdata_q;
	logic [data_width-1:0] rd_mux;
	logic                  rd_en;

	// ------------------------------
	// address accept
	// ------------------------------
	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			arready_q <= 1'b0;
			idx_q     <= '0;
		end
		else if (!arready_q && S_AXI_ARVALID_i && !rvalid_q)
		begin
			// one cycle ready pulse, nothing new while data is pending
			arready_q <= 1'b1;
			idx_q     <= S_AXI_ARADDR_i[addr_lsb +: idx_width];
		end
		else
		begin
			arready_q <= 1'b0;
		end
	end

	// ------------------------------
	// register mux
	// ------------------------------
	always_comb
	begin
		rd_mux = '0;
		case (idx_q)
			res_idx:    rd_mux = majority_i;
			state_idx:  rd_mux = {state_signature, {state_pad{1'b0}}, vote_count_i};
			// status layout is disagree, set valid, result valid from msb down
			status_idx: rd_mux = {{status_pad{1'b0}}, disagree_i, set_valid_i, result_valid_i};
			default:    rd_mux = '0;
		endcase
	end

	assign rd_en = arready_q & S_AXI_ARVALID_i & ~rvalid_q;

	// ------------------------------
	// data and response
	// ------------------------------
	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			rvalid_q <= 1'b0;
			rdata_q  <= '0;
		end
		else if (rd_en)
		begin
			// data frozen here, stays stable under back-pressure
			rvalid_q <= 1'b1;
			rdata_q  <= rd_mux;
		end
		else if (rvalid_q && S_AXI_RREADY_i)
		begin
			rvalid_q <= 1'b0;
		end
	end

	assign S_AXI_ARREADY_o = arready_q;
	assign S_AXI_RVALID_o  = rvalid_q;
	assign S_AXI_RDATA_o   = rdata_q;
	assign S_AXI_RRESP_o   = resp_okay;

endmodule

`default_nettype wire

// ==== hw/axil_write_port.sv ====
/*
 * AXI4-Lite write channel, one transaction outstanding at a time
 * AW and W must be presented together, the beat is taken as a whole
 * every write gets OKAY, the register map is decoded downstream
 */
`timescale 1ns/1ps
`default_nettype none

module axil_write_port
	import voter_pkg::*;
(
	input  wire                   S_AXI_ACLK_i,
	input  wire                   S_AXI_ARESETN_i,
	input  wire [addr_width-1:0]  S_AXI_AWADDR_i,
	input  wire                   S_AXI_AWVALID_i,
	output logic                  S_AXI_AWREADY_o,
	input  wire [data_width-1:0]  S_AXI_WDATA_i,
	input  wire [strb_width-1:0]  S_AXI_WSTRB_i,
	input  wire                   S_AXI_WVALID_i,
	output logic                  S_AXI_WREADY_o,
	output logic [1:0]            S_AXI_BRESP_o,
	output logic                  S_AXI_BVALID_o,
	input  wire                   S_AXI_BREADY_i,
	output logic                  wr_en_o,
	output logic [idx_width-1:0]  wr_idx_o,
	output logic [data_width-1:0] wr_data_o,
	output logic [strb_width-1:0] wr_strb_o
);

	// one ready flop serves both AWREADY and WREADY
	logic                 ready_q;
	// low from accept until the response is taken
	logic                 aw_en_q;
	logic                 bvalid_q;
	logic [idx_width-1:0] idx_q;
	logic                 start;

	// ------------------------------
	// accept
	// ------------------------------
	// address and data both valid, no response pending
	assign start = ~ready_q & S_AXI_AWVALID_i & S_AXI_WVALID_i & aw_en_q;

	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			ready_q <= 1'b0;
			aw_en_q <= 1'b1;
			idx_q   <= '0;
		end
		else
		begin
			// ready is a single cycle pulse
			ready_q <= start;
			if (start)
			begin
				aw_en_q <= 1'b0;
				// register index only, the 256 byte window drops the rest
				idx_q   <= S_AXI_AWADDR_i[addr_lsb +: idx_width];
			end
			else if (bvalid_q && S_AXI_BREADY_i)
			begin
				aw_en_q <= 1'b1;
			end
		end
	end

	// ------------------------------
	// response
	// ------------------------------
	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			bvalid_q <= 1'b0;
		end
		else if (wr_en_o && !bvalid_q)
		begin
			// response follows the ready pulse by one cycle
			bvalid_q <= 1'b1;
		end
		else if (bvalid_q && S_AXI_BREADY_i)
		begin
			bvalid_q <= 1'b0;
		end
	end

	assign S_AXI_AWREADY_o = ready_q;
	assign S_AXI_WREADY_o  = ready_q;
	assign S_AXI_BVALID_o  = bvalid_q;
	assign S_AXI_BRESP_o   = resp_okay;

	// write beat toward the bank, valid during the ready cycle only
	assign wr_en_o   = ready_q & S_AXI_AWVALID_i & S_AXI_WVALID_i;
	assign wr_idx_o  = idx_q;
	// data and strobes are still held by the master here
	assign wr_data_o = S_AXI_WDATA_i;
	assign wr_strb_o = S_AXI_WSTRB_i;

endmodule

`default_nettype wire

// ==== hw/majority_voter.sv ====
/*
 * registered bitwise 2-of-3 majority over the three sets
 * outputs read zero until all three sets are complete
 * the vote counter wraps at 8 bits and is zeroed by soft clear
 */
`timescale 1ns/1ps
`default_nettype none

module majority_voter
	import voter_pkg::*;
(
	input  wire                         S_AXI_ACLK_i,
	input  wire                         S_AXI_ARESETN_i,
	input  wire [data_width-1:0]        set_a_i,
	input  wire [data_width-1:0]        set_b_i,
	input  wire [data_width-1:0]        set_c_i,
	input  wire [set_num-1:0]           set_valid_i,
	input  wire                         clear_i,
	output logic [data_width-1:0]       majority_o,
	output logic [set_num-1:0]          disagree_o,
	output logic                        result_valid_o,
	output logic [vote_count_width-1:0] vote_count_o
);

	logic [data_width-1:0]       maj;
	logic [set_num-1:0]          diff;
	logic                        all_valid;
	logic [data_width-1:0]       majority_q;
	logic [set_num-1:0]          disagree_q;
	logic                        valid_q;
	logic [vote_count_width-1:0] count_q;

	// ------------------------------
	// vote
	// ------------------------------
	// a bit wins when at least two sets agree on it
	assign maj = (set_a_i & set_b_i) | (set_a_i & set_c_i) | (set_b_i & set_c_i);

	// a set disagrees if any of its bits was outvoted
	assign diff[0] = |(set_a_i ^ maj);
	assign diff[1] = |(set_b_i ^ maj);
	assign diff[2] = |(set_c_i ^ maj);

	assign all_valid = &set_valid_i;

	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			majority_q <= '0;
			disagree_q <= '0;
			valid_q    <= 1'b0;
			count_q    <= '0;
		end
		else if (clear_i)
		begin
			majority_q <= '0;
			disagree_q <= '0;
			valid_q    <= 1'b0;
			count_q    <= '0;
		end
		else
		begin
			valid_q    <= all_valid;
			// incomplete sets give a zero result, not a stale one
			majority_q <= all_valid ? maj : '0;
			disagree_q <= all_valid ? diff : '0;
			// one count per rising edge of result valid
			if (all_valid && !valid_q)
			begin
				count_q <= count_q + vote_count_width'(1);
			end
		end
	end

	assign majority_o     = majority_q;
	assign disagree_o     = disagree_q;
	assign result_valid_o = valid_q;
	assign vote_count_o   = count_q;

endmodule

`default_nettype wire

// ==== hw/root_voter_top.sv ====
/*
 * memory-mapped triple-modular voter behind an AXI4-Lite slave
 * base address must sit on a 256 byte boundary
 */
`timescale 1ns/1ps
`default_nettype none

module root_voter_top
	import voter_pkg::*;
(
	input  wire                   S_AXI_ACLK_i,
	input  wire                   S_AXI_ARESETN_i,
	input  wire [addr_width-1:0]  S_AXI_AWADDR_i,
	input  wire                   S_AXI_AWVALID_i,
	output wire                   S_AXI_AWREADY_o,
	input  wire [data_width-1:0]  S_AXI_WDATA_i,
	input  wire [strb_width-1:0]  S_AXI_WSTRB_i,
	input  wire                   S_AXI_WVALID_i,
	output wire                   S_AXI_WREADY_o,
	output wire [1:0]             S_AXI_BRESP_o,
	output wire                   S_AXI_BVALID_o,
	input  wire                   S_AXI_BREADY_i,
	input  wire [addr_width-1:0]  S_AXI_ARADDR_i,
	input  wire                   S_AXI_ARVALID_i,
	output wire                   S_AXI_ARREADY_o,
	output wire [data_width-1:0]  S_AXI_RDATA_o,
	output wire [1:0]             S_AXI_RRESP_o,
	output wire                   S_AXI_RVALID_o,
	input  wire                   S_AXI_RREADY_i
);

	// write beat into the bank
	wire                        wr_en;
	wire [idx_width-1:0]        wr_idx;
	wire [data_width-1:0]       wr_data;
	wire [strb_width-1:0]       wr_strb;
	// bank to voter
	wire [data_width-1:0]       set_a;
	wire [data_width-1:0]       set_b;
	wire [data_width-1:0]       set_c;
	wire [set_num-1:0]          set_valid;
	wire                        clear;
	// voter to read side
	wire [data_width-1:0]       majority;
	wire [set_num-1:0]          disagree;
	wire                        result_valid;
	wire [vote_count_width-1:0] vote_count;

	// ------------------------------
	// input side
	// ------------------------------
	axil_write_port u_wr (
		.S_AXI_ACLK_i(S_AXI_ACLK_i), .S_AXI_ARESETN_i(S_AXI_ARESETN_i),
		.S_AXI_AWADDR_i(S_AXI_AWADDR_i), .S_AXI_AWVALID_i(S_AXI_AWVALID_i),
		.S_AXI_AWREADY_o(S_AXI_AWREADY_o), .S_AXI_WDATA_i(S_AXI_WDATA_i),
		.S_AXI_WSTRB_i(S_AXI_WSTRB_i), .S_AXI_WVALID_i(S_AXI_WVALID_i),
		.S_AXI_WREADY_o(S_AXI_WREADY_o), .S_AXI_BRESP_o(S_AXI_BRESP_o),
		.S_AXI_BVALID_o(S_AXI_BVALID_o), .S_AXI_BREADY_i(S_AXI_BREADY_i),
		.wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data), .wr_strb_o(wr_strb)
	);

	set_register_bank u_bank (
		.S_AXI_ACLK_i(S_AXI_ACLK_i), .S_AXI_ARESETN_i(S_AXI_ARESETN_i),
		.wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
		.set_a_o(set_a), .set_b_o(set_b), .set_c_o(set_c),
		.set_valid_o(set_valid), .clear_o(clear)
	);

	// processing, one cycle behind the bank
	majority_voter u_voter (
		.S_AXI_ACLK_i(S_AXI_ACLK_i), .S_AXI_ARESETN_i(S_AXI_ARESETN_i),
		.set_a_i(set_a), .set_b_i(set_b), .set_c_i(set_c),
		.set_valid_i(set_valid), .clear_i(clear),
		.majority_o(majority), .disagree_o(disagree),
		.result_valid_o(result_valid), .vote_count_o(vote_count)
	);

	// ------------------------------
	// output side
	// ------------------------------
	axil_read_port u_rd (
		.S_AXI_ACLK_i(S_AXI_ACLK_i), .S_AXI_ARESETN_i(S_AXI_ARESETN_i),
		.S_AXI_ARADDR_i(S_AXI_ARADDR_i), .S_AXI_ARVALID_i(S_AXI_ARVALID_i),
		.S_AXI_ARREADY_o(S_AXI_ARREADY_o), .S_AXI_RDATA_o(S_AXI_RDATA_o),
		.S_AXI_RRESP_o(S_AXI_RRESP_o), .S_AXI_RVALID_o(S_AXI_RVALID_o),
		.S_AXI_RREADY_i(S_AXI_RREADY_i),
		.majority_i(majority), .disagree_i(disagree), .result_valid_i(result_valid),
		.vote_count_i(vote_count), .set_valid_i(set_valid)
	);

endmodule

`default_nettype wire

// ==== hw/set_register_bank.sv ====
/*
 * three 64 bit set registers with per-byte valid masks
 * a set counts as valid once all eight bytes were written since clear
 * writes to any other index except the command are ignored
 */
`timescale 1ns/1ps
`default_nettype none

module set_register_bank
	import voter_pkg::*;
(
	input  wire                   S_AXI_ACLK_i,
	input  wire                   S_AXI_ARESETN_i,
	input  wire                   wr_en_i,
	input  wire [idx_width-1:0]   wr_idx_i,
	input  wire [data_width-1:0]  wr_data_i,
	input  wire [strb_width-1:0]  wr_strb_i,
	output logic [data_width-1:0] set_a_o,
	output logic [data_width-1:0] set_b_o,
	output logic [data_width-1:0] set_c_o,
	output logic [set_num-1:0]    set_valid_o,
	output logic                  clear_o
);

	logic [data_width-1:0] set_q [set_num];
	logic [strb_width-1:0] mask_q [set_num];
	logic [set_num-1:0]    sel;
	logic                  clear_hit;
	logic                  clear_q;

	// ------------------------------
	// index decode
	// ------------------------------
	always_comb
	begin
		sel = '0;
		case (wr_idx_i)
			set_a_idx: sel = 3'b001;
			set_b_idx: sel = 3'b010;
			set_c_idx: sel = 3'b100;
			default:   sel = '0;
		endcase
	end

	// soft clear needs some strobe and the clear code in the low nibble
	assign clear_hit = wr_en_i && (wr_idx_i == cmd_idx) && (|wr_strb_i)
		&& (wr_data_i[$bits(clear_code)-1:0] == clear_code);

	always_ff @(posedge S_AXI_ACLK_i or negedge S_AXI_ARESETN_i)
	begin
		if (!S_AXI_ARESETN_i)
		begin
			clear_q <= 1'b0;
			for (int k = 0; k < set_num; k++)
			begin
				set_q[k]  <= '0;
				mask_q[k] <= '0;
			end
		end
		else
		begin
			// pulse tells the voter to drop its state one edge later
			clear_q <= clear_hit;
			if (clear_hit)
			begin
				for (int k = 0; k < set_num; k++)
				begin
					set_q[k]  <= '0;
					mask_q[k] <= '0;
				end
			end
			else if (wr_en_i)
			begin
				// merge strobed bytes, mark each one as written
				for (int k = 0; k < set_num; k++)
				begin
					for (int b = 0; b < strb_width; b++)
					begin
						if (sel[k] && wr_strb_i[b])
						begin
							set_q[k][b*8 +: 8] <= wr_data_i[b*8 +: 8];
							mask_q[k][b]       <= 1'b1;
						end
					end
				end
			end
		end
	end

	// ------------------------------
	// outputs
	// ------------------------------
	always_comb
	begin
		for (int k = 0; k < set_num; k++)
		begin
			set_valid_o[k] = &mask_q[k];
		end
	end

	assign set_a_o = set_q[0];
	assign set_b_o = set_q[1];
	assign set_c_o = set_q[2];
	assign clear_o = clear_q;

endmodule

`default_nettype wire

// ==== hw/voter_pkg.sv ====
/*
 * shared widths, register indices and command codes of the voter
 * bus and register width are both 64 bits, one register per beat
 * only address bits 7:3 select a register, upper bits are ignored
 */
`default_nettype none

package voter_pkg;

	// ------------------------------
	// bus geometry
	// ------------------------------
	localparam int unsigned addr_width = 12;
	localparam int unsigned data_width = 64;
	localparam int unsigned strb_width = data_width / 8;
	// byte offset bits below the register index
	localparam int unsigned addr_lsb = 3;
	// 32 registers inside a 256 byte window
	localparam int unsigned idx_width = 5;

	// number of voted input sets
	localparam int unsigned set_num = 3;

	// ------------------------------
	// register map
	// ------------------------------
	// write-only set registers
	localparam logic [idx_width-1:0] set_a_idx = 5'd1;
	localparam logic [idx_width-1:0] set_b_idx = 5'd2;
	localparam logic [idx_width-1:0] set_c_idx = 5'd3;
	// read-only result and housekeeping words
	localparam logic [idx_width-1:0] res_idx = 5'd10;
	localparam logic [idx_width-1:0] state_idx = 5'd19;
	localparam logic [idx_width-1:0] status_idx = 5'd20;
	// command register, soft clear lives here
	localparam logic [idx_width-1:0] cmd_idx = 5'd31;

	// low nibble of a command write that clears the bank
	localparam logic [3:0] clear_code = 4'hF;
	// upper half of the state register
	localparam logic [31:0] state_signature = 32'h5555_5555;
	localparam int unsigned vote_count_width = 8;

	// AXI response code, only OKAY is ever returned
	localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the voter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module root_voter_tb -Mdir obj_dir -o root_voter_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/root_voter_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0

// ==== tests/root_voter_tb.sv ====
/*
 * testbench for the AXI4-Lite voter with random data from a fixed xorshift seed
 * set registers are write-only so stored values are seen through the majority
 * the run is bounded by a cycle counter sized from the transaction count
 */
`timescale 1ns/1ps
`default_nettype none

module root_voter_tb;

	// register map as seen from the bus
	localparam logic [4:0] reg_set_a = 5'd1;
	localparam logic [4:0] reg_res = 5'd10;
	localparam logic [4:0] reg_state = 5'd19;
	localparam logic [4:0] reg_status = 5'd20;
	localparam logic [4:0] reg_cmd = 5'd31;

	// about 430 bus transactions of well under 20 cycles each
	localparam int trans_budget = 440;
	localparam int max_cycles = trans_budget * 20 + 1000;

	logic        aclk;
	logic        aresetn;
	logic [11:0] awaddr;
	logic        awvalid;
	wire         awready;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        wvalid;
	wire         wready;
	wire  [1:0]  bresp;
	wire         bvalid;
	logic        bready;
	logic [11:0] araddr;
	logic        arvalid;
	wire         arready;
	wire  [63:0] rdata;
	wire  [1:0]  rresp;
	wire         rvalid;
	logic        rready;

	// reference model state
	logic [63:0] m_set [3];
	logic [7:0]  m_mask [3];
	logic [7:0]  m_count;

	logic [31:0] rng_state;
	int          n_errors;
	int          n_checks;
	int          cycle_cnt;

	// stimulus scratch
	logic [63:0] vals [3];
	logic [63:0] fill;
	logic [63:0] word;
	logic [31:0] r32;
	logic [7:0]  strb;
	logic [4:0]  hs;
	int          victim;
	int          ncorrupt;
	int          t;

	root_voter_top u_dut (
		.S_AXI_ACLK_i(aclk), .S_AXI_ARESETN_i(aresetn),
		.S_AXI_AWADDR_i(awaddr), .S_AXI_AWVALID_i(awvalid), .S_AXI_AWREADY_o(awready),
		.S_AXI_WDATA_i(wdata), .S_AXI_WSTRB_i(wstrb), .S_AXI_WVALID_i(wvalid),
		.S_AXI_WREADY_o(wready), .S_AXI_BRESP_o(bresp), .S_AXI_BVALID_o(bvalid),
		.S_AXI_BREADY_i(bready), .S_AXI_ARADDR_i(araddr), .S_AXI_ARVALID_i(arvalid),
		.S_AXI_ARREADY_o(arready), .S_AXI_RDATA_o(rdata), .S_AXI_RRESP_o(rresp),
		.S_AXI_RVALID_o(rvalid), .S_AXI_RREADY_i(rready)
	);

	// 8 ns clock
	always #4 aclk = ~aclk;

	// ------------------------------
	// timeout
	// ------------------------------
	always @(posedge aclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= max_cycles)
		begin
			$display("simulation timed out after %0d cycles", cycle_cnt);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// one xorshift32 step per call
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi, lo};
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic all_full();
		return (&m_mask[0]) && (&m_mask[1]) && (&m_mask[2]);
	endfunction

	// count the ones per bit and take the side with two or more
	function automatic logic [63:0] vote_of(input logic [63:0] a, input logic [63:0] b,
		input logic [63:0] c);
		logic [63:0] r;
		int          ones;
		r = '0;
		for (int i = 0; i < 64; i++)
		begin
			ones = 0;
			if (a[i])
				ones++;
			if (b[i])
				ones++;
			if (c[i])
				ones++;
			r[i] = (ones >= 2);
		end
		return r;
	endfunction

	task automatic model_update(input logic [4:0] idx, input logic [63:0] data,
		input logic [7:0] be);
		logic was_full;
		int   s;
		was_full = all_full();
		s        = int'(idx) - int'(reg_set_a);
		if (idx == reg_cmd && be != 8'h00 && data[3:0] == 4'hF)
		begin
			// soft clear drops sets, masks and the vote count
			for (int k = 0; k < 3; k++)
			begin
				m_set[k]  = '0;
				m_mask[k] = '0;
			end
			m_count = 8'd0;
		end
		else if (idx >= reg_set_a && idx <= reg_set_a + 5'd2)
		begin
			for (int b = 0; b < 8; b++)
			begin
				if (be[b])
				begin
					m_set[s][b*8 +: 8] = data[b*8 +: 8];
					m_mask[s][b]       = 1'b1;
				end
			end
		end
		// a new vote starts when the last byte of the last set lands
		if (!was_full && all_full())
			m_count = m_count + 8'd1;
	endtask

	function automatic logic [63:0] expected_read(input logic [4:0] idx);
		logic [63:0] maj;
		logic [63:0] w;
		logic        full;
		full = all_full();
		maj  = vote_of(m_set[0], m_set[1], m_set[2]);
		w    = '0;
		if (idx == reg_res)
		begin
			if (full)
				w = maj;
		end
		else if (idx == reg_state)
		begin
			w = {32'h5555_5555, 24'h0, m_count};
		end
		else if (idx == reg_status)
		begin
			w[0] = full;
			for (int k = 0; k < 3; k++)
			begin
				w[1 + k] = &m_mask[k];
				// disagree bits read zero until the vote is complete
				if (full)
					w[4 + k] = (m_set[k] != maj);
			end
		end
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		n_errors++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	// ------------------------------
	// bus tasks
	// ------------------------------
	task automatic write_reg(input logic [4:0] idx, input logic [63:0] data,
		input logic [7:0] be);
		int hold;
		awaddr  = {4'h0, idx, 3'b000};
		wdata   = data;
		wstrb   = be;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		// ready seen after an edge means the beat is taken on the next one
		do
		begin
			@(posedge aclk);
			#1;
		end
		while (!awready);
		n_checks++;
		if (wready !== 1'b1)
			report_mismatch("WREADY", {63'd0, wready}, 64'd1);
		@(posedge aclk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
		begin
			@(posedge aclk);
			#1;
		end
		hold = next_rand() & 32'd3;
		repeat (hold)
		begin
			@(posedge aclk);
			#1;
			if (!bvalid)
			begin
				n_errors++;
				$display("Error at %0t: BVALID dropped before BREADY", $time);
			end
		end
		if (bresp !== 2'b00)
			report_mismatch("BRESP", {62'd0, bresp}, 64'd0);
		bready = 1'b1;
		@(posedge aclk);
		#1;
		bready = 1'b0;
		model_update(idx, data, be);
	endtask

	task automatic read_reg(input logic [4:0] idx, output logic [63:0] data);
		int          hold;
		logic [63:0] first;
		araddr  = {4'h0, idx, 3'b000};
		arvalid = 1'b1;
		do
		begin
			@(posedge aclk);
			#1;
		end
		while (!arready);
		@(posedge aclk);
		#1;
		arvalid = 1'b0;
		while (!rvalid)
		begin
			@(posedge aclk);
			#1;
		end
		first = rdata;
		// data must not move under back-pressure
		hold = next_rand() & 32'd3;
		repeat (hold)
		begin
			@(posedge aclk);
			#1;
			if (!rvalid)
			begin
				n_errors++;
				$display("Error at %0t: RVALID dropped before RREADY", $time);
			end
			if (rdata !== first)
				report_mismatch("RDATA under back-pressure", rdata, first);
		end
		if (rresp !== 2'b00)
			report_mismatch("RRESP", {62'd0, rresp}, 64'd0);
		data  = first;
		rready = 1'b1;
		@(posedge aclk);
		#1;
		rready = 1'b0;
	endtask

	task automatic check_read(input logic [4:0] idx, input string name);
		logic [63:0] got;
		logic [63:0] exp;
		read_reg(idx, got);
		exp = expected_read(idx);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		aclk      = 1'b0;
		aresetn   = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		rng_state = 32'd49122;
		n_errors  = 0;
		n_checks  = 0;
		cycle_cnt = 0;
		m_count   = 8'd0;
		for (int k = 0; k < 3; k++)
		begin
			m_set[k]  = '0;
			m_mask[k] = '0;
		end

		repeat (8) @(posedge aclk);
		#1;
		aresetn = 1'b1;

		// handshake outputs idle and registers empty after reset
		hs = {awready, wready, bvalid, arready, rvalid};
		n_checks++;
		if (hs !== 5'b0)
			report_mismatch("ready/valid outputs", {59'd0, hs}, 64'd0);
		check_read(reg_state, "state after reset");
		check_read(reg_status, "status after reset");

		// full writes with one or two sets corrupted
		for (int it = 0; it < 60; it++)
		begin
			fill     = rand64();
			vals[0]  = fill;
			vals[1]  = fill;
			vals[2]  = fill;
			ncorrupt = 1 + int'(next_rand() & 32'd1);
			victim   = int'(next_rand() % 32'd3);
			vals[victim] = vals[victim] ^ (rand64() | 64'h1);
			if (ncorrupt == 2)
				vals[(victim + 1) % 3] = vals[(victim + 1) % 3] ^ (rand64() | 64'h100);
			write_reg(5'd1, vals[0], 8'hFF);
			write_reg(5'd2, vals[1], 8'hFF);
			write_reg(5'd3, vals[2], 8'hFF);
			check_read(reg_res, "result");
			check_read(reg_status, "status");
			// a clear now and then makes the next round a fresh vote
			if (it % 20 == 19)
				write_reg(reg_cmd, 64'hF, 8'h01);
		end
		check_read(reg_state, "state after random votes");

		// partial strobes with the two other sets complementing each other
		// so the result shows the partially written set bit for bit
		for (t = 0; t < 3; t++)
		begin
			write_reg(reg_cmd, 64'hF, 8'h01);
			fill = rand64();
			write_reg(5'((t + 1) % 3 + 1), fill, 8'hFF);
			write_reg(5'((t + 2) % 3 + 1), ~fill, 8'hFF);
			for (int w = 0; w < 8 && !(&m_mask[t]); w++)
			begin
				r32  = next_rand();
				strb = (w == 7) ? 8'hFF : r32[7:0];
				write_reg(5'(t + 1), rand64(), strb);
				check_read(reg_status, "status during partial fill");
			end
			check_read(reg_res, "merged set through result");
		end

		// soft clear
		write_reg(5'd1, rand64(), 8'hFF);
		write_reg(5'd2, rand64(), 8'hFF);
		write_reg(5'd3, rand64(), 8'hFF);
		check_read(reg_state, "state before clear");
		write_reg(reg_cmd, 64'h0F, 8'h01);
		check_read(reg_status, "status after clear");
		check_read(reg_res, "result after clear");
		check_read(reg_state, "state after clear");
		write_reg(5'd1, rand64(), 8'hFF);
		write_reg(5'd2, rand64(), 8'hFF);
		write_reg(5'd3, rand64(), 8'hFF);
		// another nibble and then the clear nibble with no strobes
		word      = rand64();
		word[3:0] = 4'hE;
		write_reg(reg_cmd, word, 8'hFF);
		write_reg(reg_cmd, 64'hF, 8'h00);
		check_read(reg_status, "status after non-clear command");
		check_read(reg_res, "result after non-clear command");
		check_read(reg_state, "state after non-clear command");

		// writes to read-only and unmapped indices before reading the whole map
		write_reg(reg_res, rand64(), 8'hFF);
		write_reg(reg_state, rand64(), 8'hFF);
		write_reg(reg_status, rand64(), 8'hFF);
		write_reg(5'd0, rand64(), 8'hFF);
		write_reg(5'd4, rand64(), 8'hFF);
		write_reg(5'd17, rand64(), 8'hFF);
		write_reg(5'd30, rand64(), 8'hFF);
		for (int i = 0; i < 32; i++)
			check_read(5'(i), $sformatf("RDATA index %0d", i));

		// vote count over the whole run
		check_read(reg_state, "final vote count");

		$display("checks %0d, errors %0d, cycles %0d", n_checks, n_errors, cycle_cnt);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
